//--- Bender.yml
package:
  name: uart_str_link

sources:
  - include_dirs:
      - common
    files:
      - common/uart_str_pkg.sv
      - uart/uart_tx.sv
      - uart/uart_rx.sv
      - src/str_framer.sv
      - src/str_deframer.sv
      - src/uart_control.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/tb_uart_control.sv

//--- common/uart_str_config.svh
// build-time settings for the UART string link
// string size, serial bit timing and frame delimiter
`ifndef UART_STR_CONFIG_SVH
`define UART_STR_CONFIG_SVH

// largest payload in bytes, delimiters not counted
`define STR_MAX_CHARS 32

// sys_clk cycles per serial bit
// 8 keeps simulation short, 434 gives 115200 baud from 50 MHz
`define UART_CLKS_PER_BIT 8

// frame marker, ASCII '&'
`define STR_DELIM 8'h26

`endif

//--- common/uart_str_pkg.sv
// shared types of the UART string link
// string length and buffer, string message, byte strobe
// framer and deframer state encodings
`include "uart_str_config.svh"

package uart_str_pkg;

	// length of a string in bytes
	typedef logic [7:0] str_len_t;

	// byte 0 sits in the lowest bits
	typedef logic [`STR_MAX_CHARS-1:0][7:0] str_buf_t;

	// complete string as it crosses ports
	typedef struct packed {
		str_len_t len;
		str_buf_t data;
	} str_msg_t;

	// one byte with a single-cycle strobe
	typedef struct packed {
		logic       stb;
		logic [7:0] data;
	} byte_stb_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_DELIM1,
		TX_DELIM2,
		TX_CONTENT,
		TX_DELIM3,
		TX_DELIM4
	} tx_frame_state_e;

	typedef enum logic [2:0] {
		RX_HUNT1,
		RX_HUNT2,
		RX_BODY,
		RX_BODY_AMP,
		RX_DISCARD
	} rx_frame_state_e;

endpackage

//--- filelist.f
+incdir+common
common/uart_str_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
src/str_framer.sv
src/str_deframer.sv
src/uart_control.sv
tb/tb_uart_control.sv

//--- src/str_deframer.sv
// string deframer
// hunts for "&&", collects the body up to the closing "&&"
// a single '&' in the body is kept as data
// oversized frames raise rx_err and are skipped
`timescale 1ns/1ps
`include "uart_str_config.svh"

module str_deframer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_str_pkg::byte_stb_t rx_byte,
	output uart_str_pkg::str_msg_t  rx_msg,
	output logic                    rx_busy,
	output logic                    rx_done,
	output logic                    rx_err
);

	import uart_str_pkg::*;

	localparam str_len_t MAX_LEN = str_len_t'(`STR_MAX_CHARS);

	rx_frame_state_e state;
	str_buf_t        buf_q;
	str_len_t        cnt;
	// last discarded byte was a delimiter
	logic            disc_amp;
	logic            is_delim;
	logic            fits_one;
	logic            fits_two;
	logic            wr_one;
	logic            wr_two;

	assign is_delim = rx_byte.stb && (rx_byte.data == `STR_DELIM);
	assign fits_one = (cnt < MAX_LEN);
	assign fits_two = (cnt < MAX_LEN - 8'd1);
	assign wr_one   = rx_byte.stb && !is_delim && (state == RX_BODY) && fits_one;
	// held '&' plus the byte after it
	assign wr_two   = rx_byte.stb && !is_delim && (state == RX_BODY_AMP) && fits_two;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_HUNT1;
			cnt      <= '0;
			disc_amp <= 1'b0;
			rx_busy  <= 1'b0;
			rx_done  <= 1'b0;
			rx_err   <= 1'b0;
			rx_msg   <= '0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
			if (rx_byte.stb) begin
				case (state)
					RX_HUNT1: begin
						if (is_delim)
							state <= RX_HUNT2;
					end
					RX_HUNT2: begin
						if (is_delim) begin
							state   <= RX_BODY;
							cnt     <= '0;
							rx_busy <= 1'b1;
						end else begin
							state <= RX_HUNT1;
						end
					end
					RX_BODY: begin
						if (is_delim) begin
							state <= RX_BODY_AMP;
						end else if (wr_one) begin
							cnt <= cnt + 8'd1;
						end else begin
							state    <= RX_DISCARD;
							disc_amp <= 1'b0;
							rx_busy  <= 1'b0;
							rx_err   <= 1'b1;
						end
					end
					RX_BODY_AMP: begin
						if (is_delim) begin
							state   <= RX_HUNT1;
							rx_busy <= 1'b0;
							rx_done <= 1'b1;
							rx_msg  <= '{len: cnt, data: buf_q};
						end else if (wr_two) begin
							state <= RX_BODY;
							cnt   <= cnt + 8'd2;
						end else begin
							state    <= RX_DISCARD;
							disc_amp <= 1'b0;
							rx_busy  <= 1'b0;
							rx_err   <= 1'b1;
						end
					end
					RX_DISCARD: begin
						// closing pair of the dropped frame
						if (is_delim && disc_amp) begin
							state    <= RX_HUNT1;
							disc_amp <= 1'b0;
						end else begin
							disc_amp <= is_delim;
						end
					end
					default: state <= RX_HUNT1;
				endcase
			end
		end
	end

	// working buffer
	always_ff @(posedge sys_clk) begin
		if (wr_one) begin
			buf_q[cnt] <= rx_byte.data;
		end else if (wr_two) begin
			buf_q[cnt]        <= `STR_DELIM;
			buf_q[cnt + 8'd1] <= rx_byte.data;
		end
	end

	// deserializer bytes are single-cycle strobes, a frame apart
	a_byte_stb_single: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_byte.stb |=> !rx_byte.stb
	);

endmodule

//--- src/str_framer.sv
// string framer
// wraps a latched string as "&&" + content + "&&"
// one byte handed to the serializer per tx_byte_done
`timescale 1ns/1ps
`include "uart_str_config.svh"

module str_framer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_str_pkg::str_msg_t  tx_msg,
	input  logic                    tx_req,
	output logic                    tx_busy,
	output logic                    tx_done,
	output uart_str_pkg::byte_stb_t tx_byte,
	input  logic                    tx_byte_done
);

	import uart_str_pkg::*;

	tx_frame_state_e state;
	str_msg_t        msg_q;
	// index of the next content byte
	str_len_t        idx;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= TX_IDLE;
			idx     <= '0;
			tx_done <= 1'b0;
			tx_byte <= '0;
		end else begin
			tx_done     <= 1'b0;
			tx_byte.stb <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_req) begin
						state   <= TX_DELIM1;
						tx_byte <= '{stb: 1'b1, data: `STR_DELIM};
					end
				end
				TX_DELIM1: begin
					if (tx_byte_done) begin
						state   <= TX_DELIM2;
						tx_byte <= '{stb: 1'b1, data: `STR_DELIM};
					end
				end
				TX_DELIM2: begin
					if (tx_byte_done) begin
						// empty string goes straight to the closing pair
						if (msg_q.len == '0) begin
							state   <= TX_DELIM3;
							tx_byte <= '{stb: 1'b1, data: `STR_DELIM};
						end else begin
							state   <= TX_CONTENT;
							idx     <= 8'd1;
							tx_byte <= '{stb: 1'b1, data: msg_q.data[0]};
						end
					end
				end
				TX_CONTENT: begin
					if (tx_byte_done) begin
						if (idx == msg_q.len) begin
							state   <= TX_DELIM3;
							tx_byte <= '{stb: 1'b1, data: `STR_DELIM};
						end else begin
							idx     <= idx + 8'd1;
							tx_byte <= '{stb: 1'b1, data: msg_q.data[idx]};
						end
					end
				end
				TX_DELIM3: begin
					if (tx_byte_done) begin
						state   <= TX_DELIM4;
						tx_byte <= '{stb: 1'b1, data: `STR_DELIM};
					end
				end
				TX_DELIM4: begin
					if (tx_byte_done) begin
						state   <= TX_IDLE;
						tx_done <= 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// message captured on acceptance only
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req)
			msg_q <= tx_msg;
	end

	assign tx_busy = (state != TX_IDLE);

	a_len_in_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(state != TX_IDLE) |-> (msg_q.len <= str_len_t'(`STR_MAX_CHARS))
	);

endmodule

//--- src/uart_control.sv
// UART string link top level
// transmit path: framer into 8N1 serializer
// receive path: 8N1 deserializer into deframer
`timescale 1ns/1ps

module uart_control (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,

	input  uart_str_pkg::str_msg_t tx_msg,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,

	output uart_str_pkg::str_msg_t rx_msg,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_err,

	input  logic                   uart_rx_port,
	output logic                   uart_tx_port
);

	import uart_str_pkg::*;

	byte_stb_t tx_byte;
	logic      tx_byte_done;
	byte_stb_t rx_byte;

	str_framer u_framer (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.tx_byte      (tx_byte),
		.tx_byte_done (tx_byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_byte      (tx_byte),
		.txd          (uart_tx_port),
		.tx_byte_done (tx_byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte)
	);

	str_deframer u_deframer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_err    (rx_err)
	);

endmodule

//--- tb/tb_uart_control.sv
// testbench for the UART string link
// serial line model, response monitors and check task
// directed tests for reset, transmit, loopback, parsing and overflow
`timescale 1ns/1ps
`include "uart_str_config.svh"

module tb_uart_control;

	import uart_str_pkg::*;

	localparam int CLK_NS = 4;
	localparam int BIT_NS = `UART_CLKS_PER_BIT * CLK_NS;
	localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
	// byte frames summed over all tests, quiet periods included
	localparam int TOTAL_FRAMES = 300;
	localparam longint WATCHDOG_NS = 2 * TOTAL_FRAMES * 10 * BIT_NS;

	logic       sys_clk;
	logic       sys_rst_n;
	str_msg_t   tx_msg;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	str_msg_t   rx_msg;
	logic       rx_busy;
	logic       rx_done;
	logic       rx_err;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       loopback;
	logic       line_drv;

	logic [7:0] payload [`STR_MAX_CHARS+4];
	logic [7:0] line_q [$];
	str_msg_t   rx_q [$];
	int         tx_done_cnt = 0;
	int         rx_err_cnt = 0;
	int         rx_busy_rise_cnt = 0;
	logic       rx_busy_q = 1'b0;
	int         err_cnt = 0;

	assign uart_rx_port = loopback ? uart_tx_port : line_drv;

	uart_control dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	always #(CLK_NS / 2) sys_clk = ~sys_clk;

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		err_cnt++;
		$display("%0t ns: %s", $time, what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// printable, never the delimiter
	function automatic logic [7:0] random_char();
		logic [7:0] c;
		c = `STR_DELIM;
		while (c == `STR_DELIM)
			c = 8'h21 + 8'($urandom % 94);
		return c;
	endfunction

	task automatic fill_payload(input int len);
		for (int i = 0; i < len; i++)
			payload[i] = random_char();
	endtask

	function automatic str_msg_t build_msg(input int len);
		str_msg_t m;
		m = '0;
		m.len = str_len_t'(len);
		for (int i = 0; i < len; i++)
			m.data[i] = payload[i];
		return m;
	endfunction

	// 8N1 byte onto uart_rx_port, LSB first
	task automatic send_serial_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge sys_clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			line_drv = frame[i];
			repeat (`UART_CLKS_PER_BIT) @(posedge sys_clk);
			#1;
		end
	endtask

	task automatic send_frame(input int len);
		send_serial_byte(`STR_DELIM);
		send_serial_byte(`STR_DELIM);
		for (int i = 0; i < len; i++)
			send_serial_byte(payload[i]);
		send_serial_byte(`STR_DELIM);
		send_serial_byte(`STR_DELIM);
	endtask

	// samples 1 ns past the mid-bit clock edge
	task automatic recv_serial_byte(output logic [7:0] b);
		@(negedge uart_tx_port);
		#(BIT_NS / 2 + 1);
		check_value("tx start bit", uart_tx_port, 1'b0);
		for (int i = 0; i < 8; i++) begin
			#(BIT_NS);
			b[i] = uart_tx_port;
		end
		#(BIT_NS);
		check_value("tx stop bit", uart_tx_port, 1'b1);
	endtask

	task automatic request_tx(input str_msg_t m);
		@(posedge sys_clk);
		#1;
		tx_msg = m;
		tx_req = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	task automatic wait_tx_done(input int target, input int max_cycles);
		int n;
		n = 0;
		while (tx_done_cnt < target && n < max_cycles) begin
			@(posedge sys_clk);
			n++;
		end
		if (tx_done_cnt < target)
			fail_timeout("transmit path never raised tx_done");
	endtask

	task automatic wait_rx_msgs(input int target, input int max_cycles);
		int n;
		n = 0;
		while (rx_q.size() < target && n < max_cycles) begin
			@(posedge sys_clk);
			n++;
		end
		if (rx_q.size() < target)
			fail_timeout("receive path never raised rx_done");
	endtask

	task automatic check_rx_msg(input int idx, input int len);
		check_value("received length", rx_q[idx].len, len);
		for (int i = 0; i < len; i++)
			check_value("received byte", rx_q[idx].data[i], payload[i]);
	endtask

	task automatic test_reset_state();
		@(negedge sys_clk);
		check_value("uart_tx_port after reset", uart_tx_port, 1'b1);
		check_value("tx_busy after reset", tx_busy, 1'b0);
		check_value("tx_done after reset", tx_done, 1'b0);
		check_value("rx_busy after reset", rx_busy, 1'b0);
		check_value("rx_done after reset", rx_done, 1'b0);
		check_value("rx_err after reset", rx_err, 1'b0);
		check_value("rx_msg is zero after reset", rx_msg == '0, 1'b1);
	endtask

	task automatic test_transmit(input int len);
		int start_cnt;
		fill_payload(len);
		line_q.delete();
		start_cnt = tx_done_cnt;
		request_tx(build_msg(len));
		check_value("tx_busy after tx_req", tx_busy, 1'b1);
		// extra request while busy must be ignored
		repeat (3) @(posedge sys_clk);
		request_tx('1);
		wait_tx_done(start_cnt + 1, (len + 4) * FRAME_CYCLES + 50);
		// quiet line after the frame
		repeat (2 * FRAME_CYCLES) @(negedge sys_clk);
		check_value("tx_done pulses", tx_done_cnt - start_cnt, 1);
		check_value("tx_busy after tx_done", tx_busy, 1'b0);
		check_value("transmitted byte count", line_q.size(), len + 4);
		check_value("opening delimiter 1", line_q[0], `STR_DELIM);
		check_value("opening delimiter 2", line_q[1], `STR_DELIM);
		for (int i = 0; i < len; i++)
			check_value("transmitted payload byte", line_q[2 + i], payload[i]);
		check_value("closing delimiter 1", line_q[len + 2], `STR_DELIM);
		check_value("closing delimiter 2", line_q[len + 3], `STR_DELIM);
	endtask

	task automatic test_loopback(input int len);
		int start_cnt;
		fill_payload(len);
		rx_q.delete();
		start_cnt = tx_done_cnt;
		request_tx(build_msg(len));
		wait_rx_msgs(1, (len + 4) * FRAME_CYCLES + 100);
		wait_tx_done(start_cnt + 1, FRAME_CYCLES);
		check_value("rx_done count in loopback", rx_q.size(), 1);
		check_rx_msg(0, len);
	endtask

	task automatic test_rx_parsing();
		int rise0;
		rx_q.delete();
		rise0 = rx_busy_rise_cnt;
		// garbage and a lone delimiter ahead of the frame
		send_serial_byte(8'h61);
		send_serial_byte(8'h62);
		send_serial_byte(`STR_DELIM);
		send_serial_byte(8'h63);
		payload[0] = random_char();
		payload[1] = `STR_DELIM;
		payload[2] = random_char();
		send_frame(3);
		wait_rx_msgs(1, FRAME_CYCLES);
		check_rx_msg(0, 3);
		send_frame(0);
		wait_rx_msgs(2, FRAME_CYCLES);
		check_rx_msg(1, 0);
		check_value("rx_done count while parsing", rx_q.size(), 2);
		check_value("rx_err while parsing", rx_err_cnt, 0);
		@(negedge sys_clk);
		// one busy period per delivered frame
		check_value("rx_busy rises while parsing", rx_busy_rise_cnt - rise0, 2);
		check_value("rx_busy after parsing", rx_busy, 1'b0);
	endtask

	task automatic test_overflow();
		int err0;
		int rise0;
		rx_q.delete();
		err0 = rx_err_cnt;
		rise0 = rx_busy_rise_cnt;
		fill_payload(`STR_MAX_CHARS + 3);
		send_frame(`STR_MAX_CHARS + 3);
		repeat (FRAME_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		check_value("rx_err pulses on overflow", rx_err_cnt - err0, 1);
		check_value("rx_done on overflow", rx_q.size(), 0);
		check_value("rx_busy rises on overflow", rx_busy_rise_cnt - rise0, 1);
		check_value("rx_busy after overflow", rx_busy, 1'b0);
		fill_payload(5);
		send_frame(5);
		wait_rx_msgs(1, FRAME_CYCLES);
		check_rx_msg(0, 5);
		check_value("rx_err after valid frame", rx_err_cnt - err0, 1);
		check_value("rx_busy rises after valid frame", rx_busy_rise_cnt - rise0, 2);
	endtask

	// transmit line decoder
	initial begin
		logic [7:0] b;
		wait (sys_rst_n === 1'b1);
		forever begin
			recv_serial_byte(b);
			line_q.push_back(b);
		end
	end

	// strobe counters, sampled away from the active edge
	always @(negedge sys_clk) begin
		if (tx_done)
			tx_done_cnt++;
		if (rx_err)
			rx_err_cnt++;
		if (rx_done)
			rx_q.push_back(rx_msg);
		if (rx_busy && !rx_busy_q)
			rx_busy_rise_cnt++;
		rx_busy_q = rx_busy;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		tx_msg    = '0;
		tx_req    = 1'b0;
		loopback  = 1'b0;
		line_drv  = 1'b1;
		void'($urandom(15951));
		repeat (10) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		test_reset_state();
		test_transmit(0);
		test_transmit(`STR_MAX_CHARS);
		repeat (3) test_transmit(1 + $urandom % `STR_MAX_CHARS);
		loopback = 1'b1;
		test_loopback(1);
		test_loopback(1 + $urandom % `STR_MAX_CHARS);
		test_loopback(`STR_MAX_CHARS);
		loopback = 1'b0;
		test_rx_parsing();
		test_overflow();
		if (err_cnt == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Testbench failed");
			$fatal(1);
		end
	end

endmodule

//--- uart/uart_rx.sv
// 8N1 deserializer
// two-stage input synchronizer and falling edge detect
// start confirmed at half a bit, then mid-bit sampling
// bytes with a low stop bit are dropped
`timescale 1ns/1ps
`include "uart_str_config.svh"

module uart_rx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    rxd,
	output uart_str_pkg::byte_stb_t rx_byte
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             active;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	logic [7:0]       shreg;
	logic             byte_stb;
	logic             sample;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// start bit is checked at its middle, all others one bit later
	assign sample = active && (clk_cnt == ((bit_idx == 4'd0) ? CNT_HALF : CNT_LAST));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active   <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			byte_stb <= 1'b0;
		end else begin
			byte_stb <= 1'b0;
			if (!active) begin
				if (rx_prev && !rx_sync) begin
					active  <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				bit_idx <= bit_idx + 4'd1;
				// glitch, not a start bit
				if (bit_idx == 4'd0 && rx_sync)
					active <= 1'b0;
				if (bit_idx == 4'd9) begin
					active   <= 1'b0;
					byte_stb <= rx_sync;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shreg <= {rx_sync, shreg[7:1]};
	end

	assign rx_byte.stb  = byte_stb;
	assign rx_byte.data = shreg;

endmodule

//--- uart/uart_tx.sv
// 8N1 serializer
// start bit, eight data bits LSB first, one stop bit
// done strobe in the last cycle of the stop bit
`timescale 1ns/1ps
`include "uart_str_config.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_str_pkg::byte_stb_t tx_byte,
	output logic                    txd,
	output logic                    tx_byte_done
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	logic [9:0]       shreg;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (tx_byte.stb && !busy) begin
			busy    <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (busy) begin
			if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9)
					busy <= 1'b0;
				else
					bit_idx <= bit_idx + 4'd1;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// frame image, shifted out from bit 0
	always_ff @(posedge sys_clk) begin
		if (tx_byte.stb && !busy)
			shreg <= {1'b1, tx_byte.data, 1'b0};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[9:1]};
	end

	// idle line is high
	assign txd          = busy ? shreg[0] : 1'b1;
	assign tx_byte_done = busy && bit_end && (bit_idx == 4'd9);

	// the framer must wait for tx_byte_done before the next byte
	a_no_start_while_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_byte.stb |-> !busy
	);

endmodule
